/* logic/adc_feedback_regs.sv */
/*
 * adc feedback capture
 * latches pot and current words of every axis on the sample strobe
 */
`timescale 1ns/100ps

module adc_feedback_regs #(
    parameter int NUM_AXES = 4
) (
    input  logic                                          sysclk,
    input  logic                                          rst_n,
    input  logic                                          adc_valid,
    input  logic [NUM_AXES-1:0][motor_ctrl_pkg::SAMPLE_W-1:0] pot_fb,
    input  logic [NUM_AXES-1:0][motor_ctrl_pkg::SAMPLE_W-1:0] cur_fb,
    input  logic [motor_ctrl_pkg::REG_AW-1:0]             reg_raddr,
    output logic [motor_ctrl_pkg::REG_DW-1:0]             rdata_adc,
    output logic [NUM_AXES-1:0][motor_ctrl_pkg::SAMPLE_W-1:0] cur_latched,
    output logic                                          sample_valid
);
    import motor_ctrl_pkg::*;

    reg_addr_t                         ra;
    logic [NUM_AXES-1:0][SAMPLE_W-1:0] pot_latched;

    assign ra = reg_raddr;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pot_latched  <= '0;
            cur_latched  <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= adc_valid;      // latched words valid from here
            if (adc_valid) begin
                pot_latched <= pot_fb;
                cur_latched <= cur_fb;
            end
        end
    end

    // pot high half, current low half
    always_comb begin
        rdata_adc = '0;
        for (int a = 0; a < NUM_AXES; a++)
            if (ra.main.chan == 4'(a + 1))
                rdata_adc = {pot_latched[a], cur_latched[a]};
    end

endmodule

/* logic/board_status_regs.sv */
/*
 * board status / control, channel 0
 * amplifier enables, safety clear pulses and the status word
 */
`timescale 1ns/100ps

module board_status_regs #(
    parameter int NUM_AXES = 4
) (
    input  logic                              sysclk,
    input  logic                              rst_n,
    input  logic [3:0]                        board_id,
    input  logic [NUM_AXES-1:0]               amp_fault,     // from amplifiers
    input  logic [NUM_AXES-1:0]               fault,         // from safety checks
    input  logic                              reg_wen,
    input  logic [motor_ctrl_pkg::REG_AW-1:0] reg_waddr,
    input  logic [motor_ctrl_pkg::REG_DW-1:0] reg_wdata,
    output logic [motor_ctrl_pkg::REG_DW-1:0] rdata_board,
    output logic [NUM_AXES-1:0]               safety_clear,
    output logic [NUM_AXES-1:0]               amp_disable
);
    import motor_ctrl_pkg::*;

    reg_addr_t           wa;
    logic                stat_wr;       // write to channel 0 status word
    logic [NUM_AXES-1:0] amp_en;        // host enables
    logic [15:0]         en_x;          // padded copies for the 4-bit fields
    logic [15:0]         dis_x;
    logic [15:0]         flt_x;
    logic [15:0]         afl_x;

    assign wa = reg_waddr;
    assign stat_wr = reg_wen && wa.main.area == AREA_MAIN && wa.main.chan == 4'd0
                     && wa.main.offset == OFF_BOARD_STATUS;

    // one pulse per set bit in 7:4, same cycle as the write
    assign safety_clear = {NUM_AXES{stat_wr}} & reg_wdata[4 +: NUM_AXES];

    // ------------------------------------------------------------
    // enables and registered disables
    // ------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_en      <= '0;
            amp_disable <= '1;                      // amplifiers off out of reset
        end else begin
            if (stat_wr)
                amp_en <= reg_wdata[NUM_AXES-1:0];
            amp_disable <= ~amp_en | fault;         // one cycle behind en / fault
        end
    end

    assign en_x  = 16'(amp_en);
    assign dis_x = 16'(amp_disable);
    assign flt_x = 16'(fault);
    assign afl_x = 16'(amp_fault);

    // id | disable | fault | amp fault | ... | enable
    assign rdata_board = {board_id, dis_x[3:0], flt_x[3:0], afl_x[3:0],
                          12'h000, en_x[3:0]};

endmodule

/* logic/dac_cmd_regs.sv */
/*
 * dac current command registers
 * one offset-binary command per axis, with readback
 */
`timescale 1ns/100ps

module dac_cmd_regs #(
    parameter int NUM_AXES = 4
) (
    input  logic                                          sysclk,
    input  logic                                          rst_n,
    input  logic                                          reg_wen,
    input  logic [motor_ctrl_pkg::REG_AW-1:0]             reg_waddr,
    input  logic [motor_ctrl_pkg::REG_DW-1:0]             reg_wdata,
    input  logic [motor_ctrl_pkg::REG_AW-1:0]             reg_raddr,
    output logic [motor_ctrl_pkg::REG_DW-1:0]             rdata_dac,
    output logic [NUM_AXES-1:0][motor_ctrl_pkg::SAMPLE_W-1:0] dac_cmd
);
    import motor_ctrl_pkg::*;

    reg_addr_t wa;
    reg_addr_t ra;
    logic      dac_wr;          // write to some channel's dac offset

    assign wa = reg_waddr;
    assign ra = reg_raddr;
    assign dac_wr = reg_wen && wa.main.area == AREA_MAIN && wa.main.offset == OFF_DAC_CTRL;

    // channel a+1 holds axis a
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            dac_cmd <= {NUM_AXES{MIDSCALE}};        // zero current
        end else begin
            for (int a = 0; a < NUM_AXES; a++)
                if (dac_wr && wa.main.chan == 4'(a + 1))
                    dac_cmd[a] <= reg_wdata[SAMPLE_W-1:0];
        end
    end

    // readback, 0 for channels with no axis
    always_comb begin
        rdata_dac = '0;
        for (int a = 0; a < NUM_AXES; a++)
            if (ra.main.chan == 4'(a + 1))
                rdata_dac = {{(REG_DW - SAMPLE_W){1'b0}}, dac_cmd[a]};
    end

    a_wen_known: assert property (@(posedge sysclk) disable iff (!rst_n)
        !$isunknown(reg_wen))
        else $error("reg_wen unknown out of reset");

endmodule

/* logic/hub_reg_file.sv */
/*
 * hub register area
 * 16 read/write words, combinational readback
 */
`timescale 1ns/100ps

module hub_reg_file (
    input  logic                              sysclk,
    input  logic                              rst_n,
    input  logic                              reg_wen,
    input  logic [motor_ctrl_pkg::REG_AW-1:0] reg_waddr,
    input  logic [motor_ctrl_pkg::REG_DW-1:0] reg_wdata,
    input  logic [motor_ctrl_pkg::REG_AW-1:0] reg_raddr,
    output logic [motor_ctrl_pkg::REG_DW-1:0] rdata_hub
);
    import motor_ctrl_pkg::*;

    reg_addr_t         wa;              // write address, hub view
    reg_addr_t         ra;              // read address, hub view
    logic [REG_DW-1:0] hub_mem [0:15];

    assign wa = reg_waddr;
    assign ra = reg_raddr;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                hub_mem[i] <= '0;
        end else if (reg_wen && wa.hub.area == AREA_HUB) begin
            hub_mem[wa.hub.index] <= reg_wdata;     // write lands at the pulse edge
        end
    end

    assign rdata_hub = hub_mem[ra.hub.index];       // mux checks the area

endmodule

/* logic/motor_ctrl_pkg.sv */
/*
 * motor controller register core package
 * bus widths, address map and the two views of a register address
 */
package motor_ctrl_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int REG_AW   = 16;           // host register address
    localparam int REG_DW   = 32;           // host register data
    localparam int SAMPLE_W = 16;           // adc / dac word, offset binary

    localparam logic [SAMPLE_W-1:0] MIDSCALE = 16'h8000;   // zero current

    // ------------------------------------------------------------
    // address map
    // ------------------------------------------------------------
    localparam logic [3:0] AREA_MAIN = 4'd0;    // board + axis channels
    localparam logic [3:0] AREA_HUB  = 4'd1;    // hub register area

    // offsets inside an axis channel
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;     // pot / cur feedback
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;     // current command

    // offset inside channel 0
    localparam logic [3:0] OFF_BOARD_STATUS = 4'd0; // status / control word

    // register address word
    // main area splits into channel and offset
    // hub area uses a flat 4-bit index
    typedef union packed {
        struct packed {
            logic [3:0] area;
            logic [3:0] rsvd;
            logic [3:0] chan;       // 0 board, 1..NUM_AXES axes
            logic [3:0] offset;
        } main;
        struct packed {
            logic [3:0] area;
            logic [7:0] rsvd;
            logic [3:0] index;      // hub word
        } hub;
    } reg_addr_t;

endpackage

/* logic/motor_ctrl_top.sv */
/*
 * four-axis motor controller register core
 * hub area, dac commands, adc capture, safety checks and board status
 */
`timescale 1ns/100ps

module motor_ctrl_top #(
    parameter int NUM_AXES = 4,
    parameter int SAFETY_COUNT = 4,
    parameter logic [motor_ctrl_pkg::SAMPLE_W-1:0] SAFETY_MARGIN = 16'h0100
) (
    input  logic                                          sysclk,
    input  logic                                          rst_n,
    input  logic [3:0]                                    board_id,   // rotary switch
    // host register bus
    input  logic                                          reg_wen,
    input  logic [motor_ctrl_pkg::REG_AW-1:0]             reg_waddr,
    input  logic [motor_ctrl_pkg::REG_DW-1:0]             reg_wdata,
    input  logic [motor_ctrl_pkg::REG_AW-1:0]             reg_raddr,
    output logic [motor_ctrl_pkg::REG_DW-1:0]             reg_rdata,
    // converters, parallel words
    input  logic                                          adc_valid,
    input  logic [NUM_AXES-1:0][motor_ctrl_pkg::SAMPLE_W-1:0] pot_fb,
    input  logic [NUM_AXES-1:0][motor_ctrl_pkg::SAMPLE_W-1:0] cur_fb,
    output logic [NUM_AXES-1:0][motor_ctrl_pkg::SAMPLE_W-1:0] dac_cmd,
    // amplifiers
    input  logic [NUM_AXES-1:0]                           amp_fault,
    output logic [NUM_AXES-1:0]                           amp_disable
);
    import motor_ctrl_pkg::*;

    // ------------------------------------------------------------
    // local wires
    // ------------------------------------------------------------
    logic [REG_DW-1:0] rdata_hub;       // per-block read words
    logic [REG_DW-1:0] rdata_board;
    logic [REG_DW-1:0] rdata_adc;
    logic [REG_DW-1:0] rdata_dac;

    logic [NUM_AXES-1:0][SAMPLE_W-1:0] cur_latched;    // held feedback current
    logic                              sample_valid;   // adc_valid, one cycle later
    logic [NUM_AXES-1:0]               fault;          // latched overcurrent
    logic [NUM_AXES-1:0]               safety_clear;   // per-axis clear pulse

    reg_read_mux u_read_mux (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_raddr   (reg_raddr),
        .rdata_hub   (rdata_hub),
        .rdata_board (rdata_board),
        .rdata_adc   (rdata_adc),
        .rdata_dac   (rdata_dac),
        .reg_rdata   (reg_rdata)        // out: registered read word
    );

    hub_reg_file u_hub (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_raddr (reg_raddr),
        .rdata_hub (rdata_hub)
    );

    dac_cmd_regs #(.NUM_AXES(NUM_AXES)) u_dac (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_raddr (reg_raddr),
        .rdata_dac (rdata_dac),
        .dac_cmd   (dac_cmd)            // out: current commands
    );

    adc_feedback_regs #(.NUM_AXES(NUM_AXES)) u_adc (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .adc_valid    (adc_valid),
        .pot_fb       (pot_fb),
        .cur_fb       (cur_fb),
        .reg_raddr    (reg_raddr),
        .rdata_adc    (rdata_adc),
        .cur_latched  (cur_latched),
        .sample_valid (sample_valid)
    );

    // channel 0
    board_status_regs #(.NUM_AXES(NUM_AXES)) u_board (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .board_id     (board_id),
        .amp_fault    (amp_fault),
        .fault        (fault),
        .reg_wen      (reg_wen),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .rdata_board  (rdata_board),
        .safety_clear (safety_clear),
        .amp_disable  (amp_disable)
    );

    // ------------------------------------------------------------
    // safety check, feedback current against twice the command
    // ------------------------------------------------------------
    for (genvar a = 0; a < NUM_AXES; a++) begin : g_safe
        safety_check #(
            .SAFETY_COUNT  (SAFETY_COUNT),
            .SAFETY_MARGIN (SAFETY_MARGIN)
        ) u_safe (
            .sysclk       (sysclk),
            .rst_n        (rst_n),
            .cur_fb       (cur_latched[a]),
            .cur_cmd      (dac_cmd[a]),
            .sample_valid (sample_valid),
            .clear        (safety_clear[a]),
            .fault        (fault[a])
        );
    end

endmodule

/* logic/reg_read_mux.sv */
/*
 * register read mux
 * picks hub, board, adc or dac word by read address and registers it
 */
`timescale 1ns/100ps

module reg_read_mux (
    input  logic                              sysclk,
    input  logic                              rst_n,
    input  logic [motor_ctrl_pkg::REG_AW-1:0] reg_raddr,
    input  logic [motor_ctrl_pkg::REG_DW-1:0] rdata_hub,
    input  logic [motor_ctrl_pkg::REG_DW-1:0] rdata_board,
    input  logic [motor_ctrl_pkg::REG_DW-1:0] rdata_adc,
    input  logic [motor_ctrl_pkg::REG_DW-1:0] rdata_dac,
    output logic [motor_ctrl_pkg::REG_DW-1:0] reg_rdata
);
    import motor_ctrl_pkg::*;

    reg_addr_t         ra;          // read address, main view used here
    logic [REG_DW-1:0] rdata_sel;   // selected word before the register

    assign ra = reg_raddr;

    // area first, then channel 0 vs axis, then offset
    always_comb begin
        rdata_sel = '0;                             // unmapped reads give 0
        if (ra.main.area == AREA_HUB) begin
            rdata_sel = rdata_hub;
        end else if (ra.main.area == AREA_MAIN) begin
            if (ra.main.chan == 4'd0) begin
                if (ra.main.offset == OFF_BOARD_STATUS)
                    rdata_sel = rdata_board;
            end else if (ra.main.offset == OFF_ADC_DATA) begin
                rdata_sel = rdata_adc;              // 0 above NUM_AXES
            end else if (ra.main.offset == OFF_DAC_CTRL) begin
                rdata_sel = rdata_dac;
            end
        end
    end

    // data shows one cycle after the address
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            reg_rdata <= '0;
        else
            reg_rdata <= rdata_sel;
    end

    // host must always present a defined area
    a_area_known: assert property (@(posedge sysclk) disable iff (!rst_n)
        !$isunknown(ra.main.area))
        else $error("read address area unknown");

endmodule

/* logic/safety_check.sv */
/*
 * per-axis overcurrent monitor
 * trips after SAFETY_COUNT consecutive samples above twice the command
 */
`timescale 1ns/100ps

module safety_check #(
    parameter int SAFETY_COUNT = 4,
    parameter logic [motor_ctrl_pkg::SAMPLE_W-1:0] SAFETY_MARGIN = 16'h0100
) (
    input  logic                                sysclk,
    input  logic                                rst_n,
    input  logic [motor_ctrl_pkg::SAMPLE_W-1:0] cur_fb,       // latched feedback
    input  logic [motor_ctrl_pkg::SAMPLE_W-1:0] cur_cmd,      // dac command
    input  logic                                sample_valid,
    input  logic                                clear,
    output logic                                fault
);
    import motor_ctrl_pkg::*;

    localparam int CW = $clog2(SAFETY_COUNT + 1);

    logic [SAMPLE_W-1:0] mag_fb;
    logic [SAMPLE_W-1:0] mag_cmd;
    logic [SAMPLE_W+1:0] limit;         // 2*|cmd| + margin, no overflow
    logic                over;
    logic [CW-1:0]       over_cnt;      // consecutive over-limit samples

    // distance from midscale
    function automatic logic [SAMPLE_W-1:0] mag_of(input logic [SAMPLE_W-1:0] v);
        return (v >= MIDSCALE) ? v - MIDSCALE : MIDSCALE - v;
    endfunction

    assign mag_fb  = mag_of(cur_fb);
    assign mag_cmd = mag_of(cur_cmd);
    assign limit   = {1'b0, mag_cmd, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign over    = {2'b00, mag_fb} > limit;

    // ------------------------------------------------------------
    // counter and trip latch
    // ------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            over_cnt <= '0;
            fault    <= 1'b0;
        end else if (clear) begin
            over_cnt <= '0;                 // clear wins over a sample
            fault    <= 1'b0;
        end else if (sample_valid) begin
            if (!over) begin
                over_cnt <= '0;             // in-limit breaks the run
            end else begin
                if (over_cnt != CW'(SAFETY_COUNT))
                    over_cnt <= over_cnt + 1'b1;    // saturate at the trip count
                if (over_cnt >= CW'(SAFETY_COUNT - 1))
                    fault <= 1'b1;
            end
        end
    end

    // only the board clear pulse releases a trip
    a_fault_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        $fell(fault) |-> $past(clear))
        else $error("fault dropped without clear");

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the register core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_motor_ctrl \
    -o tb_motor_ctrl

sim_out=$(./obj_dir/tb_motor_ctrl)
echo "$sim_out"

echo "$sim_out" | grep -q "^Verification passed$"

/* verification/tb_cases.svh */
/*
 * stimulus and expected-value table for the register core testbench
 * board_id is 4'hA, amp_fault stays low
 */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset state";
            2:       return "hub area";
            3:       return "dac commands";
            4:       return "adc capture";
            5:       return "safety trip";
            6:       return "enable and clear";
            default: return "unnamed";
        endcase
    endfunction

    // write and read rows take test, addr, data or expected, rnd
    // sample rows take pot and cur, check rows take output select, wait cycles, expected
    function automatic void load_cases();
        logic [3:0][15:0] pot_v;
        logic [3:0][15:0] cur_ok;       // every axis inside its limit
        logic [3:0][15:0] cur_over;     // axis 0 at 0x8400 against a 0x8100 command

        pot_v    = 64'h4567_3456_2345_1234;
        cur_ok   = 64'h8123_8000_7D00_8200;
        cur_over = 64'h8123_8000_7D00_8400;

        check_row(1, 0, 1, 32'h0000_000F);              // all amplifiers off
        for (int a = 1; a <= 4; a++)
            check_row(1, a, 1, 32'h0000_8000);          // midscale
        read_row(1, 16'h0000, 32'hAF00_0000, 0);

        // random words read back right after each write
        write_row(2, 16'h1000, 32'h0, 1);
        read_row(2, 16'h1000, 32'h0, 1);
        write_row(2, 16'h1005, 32'h0, 1);
        read_row(2, 16'h1005, 32'h0, 1);
        write_row(2, 16'h100A, 32'h0, 1);
        read_row(2, 16'h100A, 32'h0, 1);
        write_row(2, 16'h100F, 32'h0, 1);
        read_row(2, 16'h100F, 32'h0, 1);
        write_row(2, 16'h3005, 32'hFFFF_FFFF, 0);       // unknown area is ignored
        read_row(2, 16'h1005, 32'h0, 1);
        read_row(2, 16'h2000, 32'h0000_0000, 0);        // unmapped area
        read_row(2, 16'h0070, 32'h0000_0000, 0);        // channel 7 has no axis
        read_row(2, 16'h0012, 32'h0000_0000, 0);        // unused offset

        write_row(3, 16'h0011, 32'hDEAD_8100, 0);
        read_row(3, 16'h0011, 32'h0000_8100, 0);
        write_row(3, 16'h0021, 32'h0000_8200, 0);
        read_row(3, 16'h0021, 32'h0000_8200, 0);
        write_row(3, 16'h0031, 32'h1234_7F00, 0);
        read_row(3, 16'h0031, 32'h0000_7F00, 0);
        write_row(3, 16'h0041, 32'h0000_8050, 0);
        read_row(3, 16'h0041, 32'h0000_8050, 0);
        check_row(3, 1, 1, 32'h0000_8100);
        check_row(3, 2, 1, 32'h0000_8200);
        check_row(3, 3, 1, 32'h0000_7F00);
        check_row(3, 4, 1, 32'h0000_8050);

        sample_row(4, pot_v, cur_ok);
        read_row(4, 16'h0010, 32'h1234_8200, 0);
        read_row(4, 16'h0020, 32'h2345_7D00, 0);
        read_row(4, 16'h0030, 32'h3456_8000, 0);
        read_row(4, 16'h0040, 32'h4567_8123, 0);

        write_row(5, 16'h0000, 32'h0000_000F, 0);       // enable all axes
        check_row(5, 0, 2, 32'h0000_0000);
        for (int i = 0; i < 3; i++)
            sample_row(5, pot_v, cur_over);             // one short of a trip
        sample_row(5, pot_v, cur_ok);                   // run broken here
        read_row(5, 16'h0000, 32'hA000_000F, 0);
        for (int i = 0; i < 3; i++)
            sample_row(5, pot_v, cur_over);             // fresh run still short
        read_row(5, 16'h0000, 32'hA000_000F, 0);
        sample_row(5, pot_v, cur_over);
        read_row(5, 16'h0000, 32'hA110_000F, 0);        // axis 0 tripped
        check_row(5, 0, 1, 32'h0000_0001);

        write_row(6, 16'h0000, 32'h0000_0000, 0);
        check_row(6, 0, 2, 32'h0000_000F);
        write_row(6, 16'h0000, 32'h0000_000F, 0);
        check_row(6, 0, 2, 32'h0000_0001);              // faulted axis stays off
        write_row(6, 16'h0000, 32'h0000_0015, 0);       // clear axis 0 and enable 0101
        check_row(6, 0, 2, 32'h0000_000A);
        read_row(6, 16'h0000, 32'hAA00_0005, 0);
        write_row(6, 16'h0000, 32'h0000_000F, 0);
        check_row(6, 0, 2, 32'h0000_0000);
    endfunction

`endif

/* verification/tb_motor_ctrl.sv */
/*
 * testbench for the motor controller register core
 * walks a table of bus, adc and output operations and checks each result
 */
`timescale 1ns/100ps

module tb_motor_ctrl;
    import motor_ctrl_pkg::*;

    localparam int NUM_AXES = 4;

    localparam logic [1:0] OP_WR  = 2'd0;   // host write pulse
    localparam logic [1:0] OP_RD  = 2'd1;   // host read and compare
    localparam logic [1:0] OP_SMP = 2'd2;   // adc_valid pulse
    localparam logic [1:0] OP_CHK = 2'd3;   // wait, then compare an output

    typedef struct packed {
        logic [3:0]       test;
        logic [1:0]       op;
        logic             rnd;      // random hub data
        logic [15:0]      addr;     // bus address, or output select for OP_CHK
        logic [31:0]      data;     // write data, or wait cycles for OP_CHK
        logic [3:0][15:0] pot;
        logic [3:0][15:0] cur;
        logic [31:0]      exp_val;
    } case_row_t;

    logic                              sysclk;
    logic                              rst_n;
    logic [3:0]                        board_id;
    logic                              reg_wen;
    logic [REG_AW-1:0]                 reg_waddr;
    logic [REG_DW-1:0]                 reg_wdata;
    logic [REG_AW-1:0]                 reg_raddr;
    logic [REG_DW-1:0]                 reg_rdata;
    logic                              adc_valid;
    logic [NUM_AXES-1:0][SAMPLE_W-1:0] pot_fb;
    logic [NUM_AXES-1:0][SAMPLE_W-1:0] cur_fb;
    logic [NUM_AXES-1:0][SAMPLE_W-1:0] dac_cmd;
    logic [NUM_AXES-1:0]               amp_fault;
    logic [NUM_AXES-1:0]               amp_disable;

    case_row_t   rows [$];
    logic        table_ready;
    logic [31:0] hub_model [0:15];      // last random word per hub index
    integer      seed;
    int          n_pass;
    int          n_fail;
    int          t_checks;              // per-test counts
    int          t_fails;

    motor_ctrl_top u_dut (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
        .adc_valid(adc_valid), .pot_fb(pot_fb), .cur_fb(cur_fb),
        .dac_cmd(dac_cmd), .amp_fault(amp_fault), .amp_disable(amp_disable)
    );

    initial sysclk = 1'b0;
    always #5 sysclk = ~sysclk;         // 10 ns period

    // ------------------------------------------------------------
    // table building
    // ------------------------------------------------------------
    function automatic case_row_t blank_row(input int test, input logic [1:0] op);
        case_row_t r;
        r = '0;
        r.test = 4'(test);
        r.op = op;
        return r;
    endfunction

    function automatic void write_row(input int test, input logic [15:0] addr,
                                      input logic [31:0] data, input int rnd);
        case_row_t r;
        r = blank_row(test, OP_WR);
        r.addr = addr;
        r.data = data;
        r.rnd = (rnd != 0);
        rows.push_back(r);
    endfunction

    function automatic void read_row(input int test, input logic [15:0] addr,
                                     input logic [31:0] exp_val, input int rnd);
        case_row_t r;
        r = blank_row(test, OP_RD);
        r.addr = addr;
        r.exp_val = exp_val;
        r.rnd = (rnd != 0);
        rows.push_back(r);
    endfunction

    function automatic void sample_row(input int test, input logic [3:0][15:0] pot,
                                       input logic [3:0][15:0] cur);
        case_row_t r;
        r = blank_row(test, OP_SMP);
        r.pot = pot;
        r.cur = cur;
        rows.push_back(r);
    endfunction

    // sel 0 amp_disable, 1..4 dac_cmd of that axis
    function automatic void check_row(input int test, input int sel, input int wait_cyc,
                                      input logic [31:0] exp_val);
        case_row_t r;
        r = blank_row(test, OP_CHK);
        r.addr = 16'(sel);
        r.data = 32'(wait_cyc);
        r.exp_val = exp_val;
        rows.push_back(r);
    endfunction

`include "tb_cases.svh"

    // ------------------------------------------------------------
    // bus and adc drivers, all on the rising edge
    // ------------------------------------------------------------
    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        reg_wen   <= 1'b1;
        reg_waddr <= addr;
        reg_wdata <= data;
        @(posedge sysclk);              // write lands here
        reg_wen   <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(posedge sysclk);              // read word registered
        @(negedge sysclk);
        data = reg_rdata;
    endtask

    task automatic adc_pulse(input logic [3:0][15:0] pot, input logic [3:0][15:0] cur);
        @(posedge sysclk);
        pot_fb    <= pot;
        cur_fb    <= cur;
        adc_valid <= 1'b1;
        @(posedge sysclk);              // words latched
        adc_valid <= 1'b0;
        @(posedge sysclk);              // sample_valid taken by the safety checks
    endtask

    task automatic output_check(input case_row_t r, output logic [31:0] got);
        repeat (int'(r.data)) @(posedge sysclk);
        @(negedge sysclk);
        case (r.addr[2:0])
            3'd1:    got = {16'h0000, dac_cmd[0]};
            3'd2:    got = {16'h0000, dac_cmd[1]};
            3'd3:    got = {16'h0000, dac_cmd[2]};
            3'd4:    got = {16'h0000, dac_cmd[3]};
            default: got = {28'h0000000, amp_disable};
        endcase
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] exp_val,
                           input string what);
        t_checks++;
        if (got !== exp_val) begin
            $display("ERR %0t: %s gave %h, expected %h", $time, what, got, exp_val);
            t_fails++;
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic report_test(input int id);
        if (t_fails == 0)
            $display("test %0d %s: ok, %0d checks", id, test_name(id), t_checks);
        else
            $display("test %0d %s: %0d of %0d checks wrong", id, test_name(id),
                     t_fails, t_checks);
        t_checks = 0;
        t_fails  = 0;
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        case_row_t   r;
        logic [31:0] got;
        logic [31:0] wdata;
        logic [31:0] exp_val;
        string       what;
        int          cur_test;

        rst_n = 1'b0;
        board_id = 4'hA;                // rotary switch
        reg_wen = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        adc_valid = 1'b0;
        pot_fb = '0;
        cur_fb = '0;
        amp_fault = '0;
        seed = 32'h7825_3348;
        n_pass = 0;
        n_fail = 0;
        t_checks = 0;
        t_fails = 0;
        cur_test = 0;
        for (int i = 0; i < 16; i++)
            hub_model[i] = '0;
        table_ready = 1'b0;
        load_cases();
        table_ready = 1'b1;

        repeat (8) @(posedge sysclk);
        rst_n <= 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (int'(r.test) != cur_test) begin
                if (cur_test != 0)
                    report_test(cur_test);
                cur_test = int'(r.test);
            end
            case (r.op)
                OP_WR: begin
                    wdata = r.data;
                    if (r.rnd) begin
                        wdata = $random(seed);
                        hub_model[r.addr[3:0]] = wdata;     // kept for the readback
                    end
                    bus_write(r.addr, wdata);
                end
                OP_RD: begin
                    bus_read(r.addr, got);
                    exp_val = r.rnd ? hub_model[r.addr[3:0]] : r.exp_val;
                    what = $sformatf("read of %h", r.addr);
                    compare(got, exp_val, what);
                end
                OP_SMP: adc_pulse(r.pot, r.cur);
                default: begin
                    output_check(r, got);
                    if (r.addr == 16'h0000)
                        what = "amp_disable";
                    else
                        what = $sformatf("dac_cmd of axis %0d", r.addr - 16'd1);
                    compare(got, r.exp_val, what);
                end
            endcase
        end
        report_test(cur_test);

        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // ends a stuck run, about 20 cycles per row plus margin
    initial begin : watchdog
        wait (table_ready);
        repeat (rows.size() * 20 + 200) @(posedge sysclk);
        $display("watchdog expired before the test sequence finished");
        $display("Verification failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verification
logic/motor_ctrl_pkg.sv
logic/reg_read_mux.sv
logic/hub_reg_file.sv
logic/dac_cmd_regs.sv
logic/adc_feedback_regs.sv
logic/safety_check.sv
logic/board_status_regs.sv
logic/motor_ctrl_top.sv
verification/tb_motor_ctrl.sv
